// ==== verilog.f ====
+incdir+design
+incdir+testbench
design/fe_pkg.sv
design/fetch_unit.sv
design/mem_arbiter.sv
design/imem.sv
design/fetch_buffer.sv
design/fetch_top.sv
testbench/tb_fetch_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// *************************************************************************
// Compare tasks
// *************************************************************************
task automatic check_slot(input string name, input inst_slot_t exp, input inst_slot_t act);
    if (act !== exp)
    begin
        $display("Fail %s: expected pc=%h insn=%h, actual pc=%h insn=%h",
                 name, exp.pc, exp.insn, act.pc, act.insn);
        err_count++;
    end
endtask

task automatic check_word(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp)
    begin
        $display("Fail %s: expected %h, actual %h", name, exp, act);
        err_count++;
    end
endtask

task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp)
    begin
        $display("Fail %s: expected resp %b, actual resp %b", name, exp, act);
        err_count++;
    end
endtask

// *************************************************************************
// External AXI4-Lite master
// *************************************************************************
task automatic ext_write(input logic [`FE_ADDR_W-1:0] addr, input logic [63:0] data,
                         output logic [1:0] resp);
    ext_aw.addr  <= addr;
    ext_w.data   <= data;
    ext_w.strb   <= 8'hff;
    ext_aw_valid <= 1'b1;
    ext_w_valid  <= 1'b1;
    @(posedge clk);
    while (!(ext_aw_ready || ext_w_ready))
        @(posedge clk);
    if (!(ext_aw_ready && ext_w_ready))
    begin
        $display("Error in ext_write: AW and W were not accepted in the same cycle");
        err_count++;
    end
    ext_aw_valid <= 1'b0;
    ext_w_valid  <= 1'b0;
    ext_b_ready  <= 1'b1;
    @(posedge clk);
    while (!(ext_b_valid && ext_b_ready))
        @(posedge clk);
    resp = ext_b.resp;
    ext_b_ready <= 1'b0;
endtask

task automatic ext_read(input logic [`FE_ADDR_W-1:0] addr, output logic [63:0] data,
                        output logic [1:0] resp);
    ext_ar.addr  <= addr;
    ext_ar_valid <= 1'b1;
    @(posedge clk);
    while (!(ext_ar_valid && ext_ar_ready))
        @(posedge clk);
    ext_ar_valid <= 1'b0;
    ext_r_ready  <= 1'b1;
    @(posedge clk);
    while (!(ext_r_valid && ext_r_ready))
        @(posedge clk);
    data = ext_r.data;          // Value held during the transfer
    resp = ext_r.resp;
    ext_r_ready <= 1'b0;
endtask

`endif

// ==== testbench/tb_fetch_top.sv ====
`timescale 1ns/1ps
`include "fe_defs.svh"

module tb_fetch_top;
    import fe_pkg::*;

    localparam int NUM_TESTS = 6;
    localparam int IDX_W     = $clog2(`FE_MEM_WORDS);

    logic                  clk;
    logic                  rstn;
    logic                  fetch_en;
    logic                  redirect;
    logic [`FE_ADDR_W-1:0] redirect_pc;
    axi_aw_t               ext_aw;
    logic                  ext_aw_valid;
    logic                  ext_aw_ready;
    axi_w_t                ext_w;
    logic                  ext_w_valid;
    logic                  ext_w_ready;
    axi_b_t                ext_b;
    logic                  ext_b_valid;
    logic                  ext_b_ready;
    axi_ar_t               ext_ar;
    logic                  ext_ar_valid;
    logic                  ext_ar_ready;
    axi_r_t                ext_r;
    logic                  ext_r_valid;
    logic                  ext_r_ready;
    logic                  pop0;
    logic                  pop1;
    inst_slot_t            slot0;
    inst_slot_t            slot1;
    logic                  slot0_valid;
    logic                  slot1_valid;

    logic [63:0]           ref_mem [`FE_MEM_WORDS];    // Mirror of imem
    logic [`FE_ADDR_W-1:0] exp_pc;                    // Next PC due at decode
    int                    err_count;
    int                    pass_count;
    int                    fail_count;

    fetch_top i_dut (.*);

    `include "tb_checks.svh"

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        repeat (NUM_TESTS * 2000) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests finished",
                 NUM_TESTS * 2000);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Little-endian pair with the low word at the aligned address
    function automatic logic [31:0] insn_at(input logic [`FE_ADDR_W-1:0] addr);
        logic [63:0] word;
        word = ref_mem[addr[3 +: IDX_W]];
        return addr[2] ? word[63:32] : word[31:0];
    endfunction

    task automatic expect_next_slot(input string name, input inst_slot_t act);
        inst_slot_t exp;
        exp.pc   = exp_pc;
        exp.insn = insn_at(exp_pc);
        check_slot(name, exp, act);
        exp_pc = exp_pc + `FE_ADDR_W'(4);
    endtask

    task automatic restart_fetch(input logic [`FE_ADDR_W-1:0] pc);
        fetch_en    <= 1'b1;
        redirect    <= 1'b1;
        redirect_pc <= pc;
        @(posedge clk);
        redirect <= 1'b0;
        exp_pc = pc;
    endtask

    // *************************************************************************
    // Decode side pops on alternate cycles so the valids it uses stay current
    // *************************************************************************
    task automatic consume(input string name, input int n, input bit alternate);
        int got;
        bit want_two;
        got      = 0;
        want_two = 1'b0;
        while (got < n)
        begin
            @(posedge clk);
            if (pop0)
            begin
                expect_next_slot(name, slot0);
                got++;
            end
            if (pop1)
            begin
                expect_next_slot(name, slot1);
                got++;
            end
            pop0 <= 1'b0;
            pop1 <= 1'b0;
            if (!pop0 && got < n)
            begin
                if (slot1_valid && (want_two || !alternate))
                begin
                    pop0     <= 1'b1;
                    pop1     <= 1'b1;
                    want_two = 1'b0;
                end
                else if (slot0_valid && (!want_two || !alternate))
                begin
                    pop0     <= 1'b1;
                    want_two = 1'b1;
                end
            end
        end
    endtask

    task automatic check_ext_reads(input string name, input int n);
        logic [63:0] data;
        logic [1:0]  resp;
        int          idx;
        for (int i = 0; i < n; i++)
        begin
            idx = $urandom_range(`FE_MEM_WORDS - 1, 0);
            ext_read(`FE_ADDR_W'(8 * idx), data, resp);
            check_word(name, ref_mem[idx], data);
            check_resp(name, AXI_RESP_OKAY, resp);
        end
    endtask

    // *************************************************************************
    // Directed tests
    // *************************************************************************
    task automatic test_load_readback();
        logic [63:0] data;
        logic [1:0]  resp;
        if (slot0_valid || slot1_valid || ext_b_valid || ext_r_valid ||
            ext_aw_ready || ext_w_ready || ext_ar_ready)
        begin
            $display("Error in load_readback: a valid or ready output is high after reset");
            err_count++;
        end
        for (int i = 0; i < `FE_MEM_WORDS; i++)
        begin
            ref_mem[i] = {$urandom, $urandom};
            ext_write(`FE_ADDR_W'(8 * i), ref_mem[i], resp);
            check_resp("load_readback", AXI_RESP_OKAY, resp);
        end
        for (int i = 0; i < `FE_MEM_WORDS; i++)
        begin
            ext_read(`FE_ADDR_W'(8 * i), data, resp);
            check_word("load_readback", ref_mem[i], data);
            check_resp("load_readback", AXI_RESP_OKAY, resp);
        end
    endtask

    task automatic test_sequential();
        fetch_en <= 1'b1;           // PC still at reset value
        exp_pc = `FE_RESET_PC;
        consume("sequential", 64, 1'b0);
    endtask

    task automatic test_redirect_odd();
        restart_fetch(32'h0000_024c);
        consume("redirect_odd", 41, 1'b0);
    endtask

    task automatic test_backpressure();
        int idle;
        restart_fetch(32'h0000_0400);
        idle = 0;
        while (idle < 50)
        begin
            @(posedge clk);
            idle = i_dut.push ? 0 : idle + 1;
        end
        if (!slot1_valid)
        begin
            $display("Error in backpressure: buffer holds fewer than two slots while stalled");
            err_count++;
        end
        consume("backpressure", 3 * `FE_FB_DEPTH, 1'b0);
    endtask

    task automatic test_contention();
        restart_fetch(32'h0000_0600);
        fork
            consume("contention", 64, 1'b0);
            check_ext_reads("contention", 24);
        join
    endtask

    task automatic test_mixed_pops();
        restart_fetch(32'h0000_0104);
        consume("mixed_pops", 60, 1'b1);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before)
        begin
            $display("Test %s: ok", name);
            pass_count++;
        end
        else
        begin
            $display("Test %s: %0d errors", name, err_count - errs_before);
            fail_count++;
        end
    endtask

    initial
    begin
        int errs;
        void'($urandom(69417));
        err_count    = 0;
        pass_count   = 0;
        fail_count   = 0;
        rstn         = 1'b0;
        fetch_en     = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = '0;
        ext_aw       = '0;
        ext_aw_valid = 1'b0;
        ext_w        = '0;
        ext_w_valid  = 1'b0;
        ext_b_ready  = 1'b0;
        ext_ar       = '0;
        ext_ar_valid = 1'b0;
        ext_r_ready  = 1'b0;
        pop0         = 1'b0;
        pop1         = 1'b0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        errs = err_count;
        test_load_readback();
        report_test("load_readback", errs);

        errs = err_count;
        test_sequential();
        report_test("sequential", errs);

        errs = err_count;
        test_redirect_odd();
        report_test("redirect_odd", errs);

        errs = err_count;
        test_backpressure();
        report_test("backpressure", errs);

        errs = err_count;
        test_contention();
        report_test("contention", errs);

        errs = err_count;
        test_mixed_pops();
        report_test("mixed_pops", errs);

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== design/fetch_top.sv ====
`timescale 1ns/1ps
`include "fe_defs.svh"

module fetch_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  fetch_en,
    input  logic                  redirect,
    input  logic [`FE_ADDR_W-1:0] redirect_pc,
    input  fe_pkg::axi_aw_t       ext_aw,
    input  logic                  ext_aw_valid,
    output logic                  ext_aw_ready,
    input  fe_pkg::axi_w_t        ext_w,
    input  logic                  ext_w_valid,
    output logic                  ext_w_ready,
    output fe_pkg::axi_b_t        ext_b,
    output logic                  ext_b_valid,
    input  logic                  ext_b_ready,
    input  fe_pkg::axi_ar_t       ext_ar,
    input  logic                  ext_ar_valid,
    output logic                  ext_ar_ready,
    output fe_pkg::axi_r_t        ext_r,
    output logic                  ext_r_valid,
    input  logic                  ext_r_ready,
    input  logic                  pop0,
    input  logic                  pop1,
    output fe_pkg::inst_slot_t    slot0,
    output fe_pkg::inst_slot_t    slot1,
    output logic                  slot0_valid,
    output logic                  slot1_valid
);
    import fe_pkg::*;

    // Fetch master side
    axi_ar_t    f_ar;
    logic       f_ar_valid;
    logic       f_ar_ready;
    axi_r_t     f_r;
    logic       f_r_valid;
    logic       f_r_ready;

    // Memory side
    axi_aw_t    m_aw;
    logic       m_aw_valid;
    logic       m_aw_ready;
    axi_w_t     m_w;
    logic       m_w_valid;
    logic       m_w_ready;
    axi_b_t     m_b;
    logic       m_b_valid;
    logic       m_b_ready;
    axi_ar_t    m_ar;
    logic       m_ar_valid;
    logic       m_ar_ready;
    axi_r_t     m_r;
    logic       m_r_valid;
    logic       m_r_ready;

    logic       push;
    fetch_pkt_t pkt;
    logic       fb_room;

    fetch_unit i_fetch (
        .clk, .rstn, .fetch_en, .redirect, .redirect_pc,
        .ar(f_ar), .ar_valid(f_ar_valid), .ar_ready(f_ar_ready),
        .r(f_r), .r_valid(f_r_valid), .r_ready(f_r_ready),
        .push, .pkt, .fb_room
    );

    mem_arbiter i_arb (
        .clk, .rstn,
        .f_ar, .f_ar_valid, .f_ar_ready, .f_r, .f_r_valid, .f_r_ready,
        .x_aw(ext_aw), .x_aw_valid(ext_aw_valid), .x_aw_ready(ext_aw_ready),
        .x_w(ext_w), .x_w_valid(ext_w_valid), .x_w_ready(ext_w_ready),
        .x_b(ext_b), .x_b_valid(ext_b_valid), .x_b_ready(ext_b_ready),
        .x_ar(ext_ar), .x_ar_valid(ext_ar_valid), .x_ar_ready(ext_ar_ready),
        .x_r(ext_r), .x_r_valid(ext_r_valid), .x_r_ready(ext_r_ready),
        .m_aw, .m_aw_valid, .m_aw_ready, .m_w, .m_w_valid, .m_w_ready,
        .m_b, .m_b_valid, .m_b_ready,
        .m_ar, .m_ar_valid, .m_ar_ready, .m_r, .m_r_valid, .m_r_ready
    );

    imem #(
        .WORDS(`FE_MEM_WORDS)
    ) i_imem (
        .clk, .rstn,
        .aw(m_aw), .aw_valid(m_aw_valid), .aw_ready(m_aw_ready),
        .w(m_w), .w_valid(m_w_valid), .w_ready(m_w_ready),
        .b(m_b), .b_valid(m_b_valid), .b_ready(m_b_ready),
        .ar(m_ar), .ar_valid(m_ar_valid), .ar_ready(m_ar_ready),
        .r(m_r), .r_valid(m_r_valid), .r_ready(m_r_ready)
    );

    fetch_buffer #(
        .DEPTH(`FE_FB_DEPTH)
    ) i_fbuf (
        .clk, .rstn, .flush(redirect), .push, .pkt, .pop0, .pop1,
        .slot0, .slot1, .slot0_valid, .slot1_valid, .fb_room
    );

endmodule

// ==== design/fetch_buffer.sv ====
`timescale 1ns/1ps
`include "fe_defs.svh"

module fetch_buffer #(
    parameter int DEPTH = `FE_FB_DEPTH
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               flush,
    input  logic               push,
    input  fe_pkg::fetch_pkt_t pkt,
    input  logic               pop0,
    input  logic               pop1,
    output fe_pkg::inst_slot_t slot0,
    output fe_pkg::inst_slot_t slot1,
    output logic               slot0_valid,
    output logic               slot1_valid,
    output logic               fb_room
);
    import fe_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [`FE_ADDR_W-1:0] INSN_BYTES = `FE_ADDR_W'(4);

    inst_slot_t       q [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] push_n;
    logic [CNT_W-1:0] pop_n;

    assign push_n = !push ? '0 : (pkt.two ? CNT_W'(2) : CNT_W'(1));
    assign pop_n  = CNT_W'(pop0) + CNT_W'(pop1);

    // Oldest entry always sits in slot0
    assign slot0       = q[rd_ptr];
    assign slot1       = q[rd_ptr + PTR_W'(1)];
    assign slot0_valid = (count != '0);
    assign slot1_valid = (count >= CNT_W'(2));
    assign fb_room     = (count <= CNT_W'(DEPTH - 2));

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            q[wr_ptr] <= '{pc: pkt.pc, insn: pkt.insn0};
            if (pkt.two)
                q[wr_ptr + PTR_W'(1)] <= '{pc: pkt.pc + INSN_BYTES, insn: pkt.insn1};
        end
    end

    // *************************************************************************
    // Pointers and occupancy
    // *************************************************************************
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else if (flush)     // Wins over a push in the same cycle
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            rd_ptr <= rd_ptr + PTR_W'(pop_n);
            wr_ptr <= wr_ptr + PTR_W'(push_n);
            count  <= count + push_n - pop_n;
        end
    end

    a_pop_order: assert property (@(posedge clk) disable iff (!rstn)
        pop1 |-> pop0);

    a_pop_valid: assert property (@(posedge clk) disable iff (!rstn)
        (pop0 |-> slot0_valid) and (pop1 |-> slot1_valid));

    // Holds only if fetch checks room at issue
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        (push && !flush) |-> (int'(count) + int'(push_n) <= DEPTH + int'(pop_n)));

endmodule

// ==== design/imem.sv ====
`timescale 1ns/1ps
`include "fe_defs.svh"

module imem #(
    parameter int WORDS = `FE_MEM_WORDS
) (
    input  logic            clk,
    input  logic            rstn,
    input  fe_pkg::axi_aw_t aw,
    input  logic            aw_valid,
    output logic            aw_ready,
    input  fe_pkg::axi_w_t  w,
    input  logic            w_valid,
    output logic            w_ready,
    output fe_pkg::axi_b_t  b,
    output logic            b_valid,
    input  logic            b_ready,
    input  fe_pkg::axi_ar_t ar,
    input  logic            ar_valid,
    output logic            ar_ready,
    output fe_pkg::axi_r_t  r,
    output logic            r_valid,
    input  logic            r_ready
);
    import fe_pkg::*;

    localparam int IDX_W = $clog2(WORDS);

    logic [63:0]      mem [WORDS];
    logic [63:0]      rdata_q;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             busy;
    logic             ar_hs;
    logic             wr_hs;

    assign rd_idx = ar.addr[3 +: IDX_W];    // 64-bit word index
    assign wr_idx = aw.addr[3 +: IDX_W];
    assign busy   = r_valid || b_valid;

    assign ar_ready = !busy;
    assign ar_hs    = ar_valid && ar_ready;
    assign wr_hs    = aw_valid && w_valid && !busy;   // AW and W taken together
    assign aw_ready = wr_hs;
    assign w_ready  = wr_hs;

    assign r.data = rdata_q;
    assign r.resp = AXI_RESP_OKAY;
    assign b.resp = AXI_RESP_OKAY;

    always_ff @(posedge clk)
    begin
        if (wr_hs)
        begin
            for (int i = 0; i < 8; i++)
            begin
                if (w.strb[i])
                    mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
            end
        end
        if (ar_hs)
            rdata_q <= mem[rd_idx];
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            r_valid <= 1'b0;
            b_valid <= 1'b0;
        end
        else
        begin
            if (ar_hs)
                r_valid <= 1'b1;
            else if (r_ready)
                r_valid <= 1'b0;
            if (wr_hs)
                b_valid <= 1'b1;
            else if (b_ready)
                b_valid <= 1'b0;
        end
    end

endmodule

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic            clk,
    input  logic            rstn,
    input  fe_pkg::axi_ar_t f_ar,
    input  logic            f_ar_valid,
    output logic            f_ar_ready,
    output fe_pkg::axi_r_t  f_r,
    output logic            f_r_valid,
    input  logic            f_r_ready,
    input  fe_pkg::axi_aw_t x_aw,
    input  logic            x_aw_valid,
    output logic            x_aw_ready,
    input  fe_pkg::axi_w_t  x_w,
    input  logic            x_w_valid,
    output logic            x_w_ready,
    output fe_pkg::axi_b_t  x_b,
    output logic            x_b_valid,
    input  logic            x_b_ready,
    input  fe_pkg::axi_ar_t x_ar,
    input  logic            x_ar_valid,
    output logic            x_ar_ready,
    output fe_pkg::axi_r_t  x_r,
    output logic            x_r_valid,
    input  logic            x_r_ready,
    output fe_pkg::axi_aw_t m_aw,
    output logic            m_aw_valid,
    input  logic            m_aw_ready,
    output fe_pkg::axi_w_t  m_w,
    output logic            m_w_valid,
    input  logic            m_w_ready,
    input  fe_pkg::axi_b_t  m_b,
    input  logic            m_b_valid,
    output logic            m_b_ready,
    output fe_pkg::axi_ar_t m_ar,
    output logic            m_ar_valid,
    input  logic            m_ar_ready,
    input  fe_pkg::axi_r_t  m_r,
    input  logic            m_r_valid,
    output logic            m_r_ready
);
    import fe_pkg::*;

    arb_owner_e owner_q;
    arb_owner_e owner;          // Owner seen by the routing this cycle
    logic       last_ext_q;     // External master won the last grant
    logic       ext_wr_q;
    logic       ext_wr;
    logic       x_req;
    logic       f_sel;
    logic       x_rd;
    logic       x_wr;
    logic       done;

    assign x_req  = x_ar_valid || (x_aw_valid && x_w_valid);
    assign ext_wr = (owner_q == OWN_EXT) ? ext_wr_q : !x_ar_valid;  // Reads first

    always_comb
    begin
        owner = owner_q;
        if (owner_q == OWN_NONE)
        begin
            if (f_ar_valid && (!x_req || last_ext_q))
                owner = OWN_FETCH;
            else if (x_req)
                owner = OWN_EXT;
        end
    end

    assign f_sel = (owner == OWN_FETCH);
    assign x_rd  = (owner == OWN_EXT) && !ext_wr;
    assign x_wr  = (owner == OWN_EXT) && ext_wr;

    // *************************************************************************
    // Channel steering
    // *************************************************************************
    assign m_ar       = f_sel ? f_ar : x_ar;
    assign m_ar_valid = (f_sel && f_ar_valid) || (x_rd && x_ar_valid);
    assign f_ar_ready = f_sel && m_ar_ready;
    assign x_ar_ready = x_rd && m_ar_ready;

    assign f_r       = m_r;
    assign x_r       = m_r;
    assign f_r_valid = f_sel && m_r_valid;
    assign x_r_valid = x_rd && m_r_valid;
    assign m_r_ready = (f_sel && f_r_ready) || (x_rd && x_r_ready);

    assign m_aw       = x_aw;
    assign m_w        = x_w;
    assign m_aw_valid = x_wr && x_aw_valid;
    assign m_w_valid  = x_wr && x_w_valid;
    assign x_aw_ready = x_wr && m_aw_ready;
    assign x_w_ready  = x_wr && m_w_ready;
    assign x_b        = m_b;
    assign x_b_valid  = x_wr && m_b_valid;
    assign m_b_ready  = x_wr && x_b_ready;

    assign done = (m_r_valid && m_r_ready) || (m_b_valid && m_b_ready);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            owner_q    <= OWN_NONE;
            last_ext_q <= 1'b0;
            ext_wr_q   <= 1'b0;
        end
        else if (done)
            owner_q <= OWN_NONE;
        else if (owner_q == OWN_NONE && owner != OWN_NONE)
        begin
            owner_q    <= owner;
            last_ext_q <= (owner == OWN_EXT);
            ext_wr_q   <= ext_wr;
        end
    end

    // Pending response still routed to the grant that caused it
    a_resp_route: assert property (@(posedge clk) disable iff (!rstn)
        (m_r_valid || m_b_valid) |-> (m_b_valid == x_wr));

    // Memory only answers a granted master
    a_resp_owned: assert property (@(posedge clk) disable iff (!rstn)
        (m_r_valid || m_b_valid) |-> (owner_q != OWN_NONE));

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps
`include "fe_defs.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  fetch_en,
    input  logic                  redirect,
    input  logic [`FE_ADDR_W-1:0] redirect_pc,
    output fe_pkg::axi_ar_t       ar,
    output logic                  ar_valid,
    input  logic                  ar_ready,
    input  fe_pkg::axi_r_t        r,
    input  logic                  r_valid,
    output logic                  r_ready,
    output logic                  push,
    output fe_pkg::fetch_pkt_t    pkt,
    input  logic                  fb_room
);
    import fe_pkg::*;

    localparam logic [`FE_ADDR_W-1:0] PAIR_BYTES = `FE_ADDR_W'(8);

    fetch_state_e          state_q;
    fetch_state_e          state_d;
    logic [`FE_ADDR_W-1:0] pc_q;
    logic [`FE_ADDR_W-1:0] line_pc;     // Aligned pair holding pc_q
    logic [`FE_ADDR_W-1:0] ar_addr_q;
    logic                  kill_q;      // Redirect seen while AR waits
    logic                  ar_hs;

    assign line_pc = {pc_q[`FE_ADDR_W-1:3], 3'b000};
    assign ar_hs   = ar_valid && ar_ready;

    // Issue only with room for a full pair, then hold AR until taken
    assign ar_valid = (state_q == FS_IDLE && fetch_en && fb_room && !redirect) ||
                      (state_q == FS_ADDR);
    assign ar.addr  = (state_q == FS_IDLE) ? line_pc : ar_addr_q;
    assign r_ready  = (state_q == FS_DATA) || (state_q == FS_DROP);
    assign push     = (state_q == FS_DATA) && r_valid && !redirect;

    always_comb
    begin
        pkt.pc    = pc_q;
        pkt.insn0 = pc_q[2] ? r.data[63:32] : r.data[31:0];
        pkt.insn1 = r.data[63:32];
        pkt.two   = !pc_q[2];               // Odd word gives one insn
    end

    // *************************************************************************
    // Read sequencing
    // *************************************************************************
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            FS_IDLE:
                if (ar_valid)
                    state_d = ar_hs ? FS_DATA : FS_ADDR;
            FS_ADDR:
                if (ar_hs)
                    state_d = (kill_q || redirect) ? FS_DROP : FS_DATA;
            FS_DATA:
                if (r_valid)
                    state_d = FS_IDLE;
                else if (redirect)
                    state_d = FS_DROP;
            FS_DROP:
                if (r_valid)
                    state_d = FS_IDLE;   // Stale pair discarded
            default:
                state_d = FS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state_q <= FS_IDLE;
            pc_q    <= `FE_RESET_PC;
            kill_q  <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            kill_q  <= (state_q == FS_ADDR) && !ar_hs && (kill_q || redirect);
            if (redirect)
                pc_q <= redirect_pc;
            else if (push)
                pc_q <= line_pc + PAIR_BYTES;   // Next aligned pair
        end
    end

    // Keeps AR stable if pc_q moves on a redirect
    always_ff @(posedge clk)
    begin
        if (state_q == FS_IDLE)
            ar_addr_q <= line_pc;
    end

endmodule

// ==== design/fe_pkg.sv ====
`include "fe_defs.svh"

package fe_pkg;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // *************************************************************************
    // AXI4-Lite channel payloads
    // *************************************************************************
    typedef struct packed {
        logic [`FE_ADDR_W-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [63:0] data;
        logic [1:0]  resp;
    } axi_r_t;

    typedef struct packed {
        logic [`FE_ADDR_W-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  strb;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    // *************************************************************************
    // Fetch path
    // *************************************************************************
    typedef struct packed {
        logic [`FE_ADDR_W-1:0] pc;      // Address of insn0
        logic [31:0]           insn0;
        logic [31:0]           insn1;
        logic                  two;     // insn1 valid too
    } fetch_pkt_t;

    typedef struct packed {
        logic [`FE_ADDR_W-1:0] pc;
        logic [31:0]           insn;
    } inst_slot_t;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_ADDR,
        FS_DATA,
        FS_DROP
    } fetch_state_e;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_FETCH,
        OWN_EXT
    } arb_owner_e;

endpackage

// ==== design/fe_defs.svh ====
`ifndef FE_DEFS_SVH
`define FE_DEFS_SVH

`define FE_ADDR_W    32             // Byte address width
`define FE_FB_DEPTH  16             // Fetch buffer entries
`define FE_MEM_WORDS 256            // 64-bit instruction memory words
`define FE_RESET_PC  32'h0000_0000

`endif
